/* Bender.yml */
package:
  name: dcache_data_stage

sources:
  - files:
      - common/dcache_pkg.sv
      - common/mem_op_pkg.sv
      - dcache/dcache_hit_check.sv
      - dcache/l1d_data_sram.sv
      - source/store_align.sv
      - source/dcache_access_ctrl.sv
      - source/dcache_data_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_dcache_data_stage.sv

/* common/dcache_pkg.sv */
// ======================================================================
// L1 data cache geometry and address/line types.
// Shared by the data stage blocks and the memory operation package.
// The physical address is a union that is read either as tag, set and
// offset or as line index and offset.
// ======================================================================

package dcache_pkg;

    localparam int CACHE_LINE_BYTES = 64;
    localparam int CACHE_LINE_WORDS = CACHE_LINE_BYTES / 4;
    localparam int CACHE_LINE_BITS = CACHE_LINE_BYTES * 8;
    localparam int CACHE_LINE_OFFSET_WIDTH = $clog2(CACHE_LINE_BYTES);

    // Fixed, the address layout below depends on it
    localparam int NUM_SETS = 64;
    localparam int SET_IDX_WIDTH = $clog2(NUM_SETS);
    localparam int TAG_WIDTH = 32 - SET_IDX_WIDTH - CACHE_LINE_OFFSET_WIDTH;

    typedef logic [31:0] scalar_t;
    typedef logic [TAG_WIDTH-1:0] l1d_tag_t;
    typedef logic [SET_IDX_WIDTH-1:0] l1d_set_idx_t;
    typedef logic [TAG_WIDTH+SET_IDX_WIDTH-1:0] cache_line_index_t;
    typedef logic [CACHE_LINE_BITS-1:0] cache_line_data_t;
    typedef scalar_t [CACHE_LINE_WORDS-1:0] vector_t;
    typedef logic [CACHE_LINE_WORDS-1:0] vector_mask_t;

    typedef struct packed {
        l1d_tag_t tag;
        l1d_set_idx_t set_idx;
        logic [CACHE_LINE_OFFSET_WIDTH-1:0] offset;
    } l1d_tag_addr_t;

    typedef struct packed {
        cache_line_index_t line;
        logic [CACHE_LINE_OFFSET_WIDTH-1:0] offset;
    } l1d_line_addr_t;

    // Same 32-bit word, two decodings
    typedef union packed {
        l1d_tag_addr_t tag_view;
        l1d_line_addr_t line_view;
    } l1d_addr_t;

    // Tag written by the L2 side in the current cycle
    typedef struct packed {
        logic valid;
        l1d_set_idx_t set_idx;
        l1d_tag_t tag;
    } l1d_tag_fill_t;

endpackage

/* common/mem_op_pkg.sv */
// ======================================================================
// Memory operation kinds and the structs that travel through the data
// stage: the incoming request, the miss and store requests sent to
// L2, and the registered per-request result.
// ======================================================================

package mem_op_pkg;

    // Wide enough for the largest thread count supported
    localparam int THREAD_IDX_WIDTH = 4;

    typedef logic [THREAD_IDX_WIDTH-1:0] thread_idx_t;

    typedef enum logic [2:0] {
        MEM_B,
        MEM_S,
        MEM_L,
        MEM_SYNC,
        MEM_BLOCK
    } mem_op_t;

    typedef struct packed {
        logic valid;
        logic is_load;
        mem_op_t op;
        thread_idx_t thread;
        dcache_pkg::l1d_addr_t paddr;
        dcache_pkg::vector_mask_t mask;
        dcache_pkg::vector_t store_value;
    } dcache_request_t;

    typedef struct packed {
        logic en;
        logic sync;
        thread_idx_t thread;
        dcache_pkg::cache_line_index_t line;
    } miss_request_t;

    typedef struct packed {
        logic en;
        logic sync;
        thread_idx_t thread;
        dcache_pkg::cache_line_index_t line;
        logic [dcache_pkg::CACHE_LINE_BYTES-1:0] byte_mask;
        dcache_pkg::cache_line_data_t data;
    } store_request_t;

    typedef struct packed {
        logic valid;
        logic rollback;
        logic suspend;
        logic fault;
        thread_idx_t thread;
    } stage_result_t;

endpackage

/* dcache/dcache_hit_check.sv */
// ======================================================================
// Hit detection for the data stage.
// Compares the request tag against every way, encodes the hit way and
// tracks the per-thread sync load state. Also flags a near miss when
// the requested line is being filled in the same cycle.
// ======================================================================
`timescale 1ns/1ns

module dcache_hit_check #(
    parameter int NUM_WAYS = 4,
    parameter int NUM_THREADS = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  mem_op_pkg::dcache_request_t      request,
    input  logic                             way_valid[NUM_WAYS],
    input  dcache_pkg::l1d_tag_t             way_tag[NUM_WAYS],
    input  dcache_pkg::l1d_tag_fill_t        tag_fill,
    input  logic                             load_en,
    output logic                             cache_hit,
    output logic [$clog2(NUM_WAYS)-1:0]      hit_way,
    output logic                             near_miss,
    output logic [NUM_THREADS-1:0]           load_sync_pending
);

    localparam int WAY_IDX_WIDTH = $clog2(NUM_WAYS);

    logic [NUM_WAYS-1:0] way_hit_oh;
    logic [NUM_THREADS-1:0] thread_oh;
    logic is_sync;

    assign is_sync = request.op == mem_op_pkg::MEM_SYNC;

    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
            way_hit_oh[w] = way_valid[w] && way_tag[w] == request.paddr.tag_view.tag;
    end

    // At most one way holds a line, so OR-ing indices gives the encoding
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (way_hit_oh[w])
                hit_way = hit_way | WAY_IDX_WIDTH'(w);
        end
    end

    always_comb
    begin
        for (int t = 0; t < NUM_THREADS; t++)
            thread_oh[t] = request.thread == mem_op_pkg::thread_idx_t'(t);
    end

    // First sync load of a thread must go to L2 to register, so it misses
    assign cache_hit = |way_hit_oh && (!is_sync || |(load_sync_pending & thread_oh));

    // Line arriving this cycle, retry instead of waiting for a wakeup
    assign near_miss = load_en
        && !cache_hit
        && tag_fill.valid
        && tag_fill.set_idx == request.paddr.tag_view.set_idx
        && tag_fill.tag == request.paddr.tag_view.tag
        && !is_sync;

    // Toggles between first attempt and retried sync load
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            load_sync_pending <= '0;
        else if (load_en && is_sync)
            load_sync_pending <= load_sync_pending ^ thread_oh;
    end

endmodule

/* dcache/l1d_data_sram.sv */
// ======================================================================
// Line-wide L1 data array, NUM_WAYS by NUM_SETS lines.
// One registered read port for the pipeline and one write port for
// fills from L2. A same-cycle write to the read address is forwarded.
// ======================================================================
`timescale 1ns/1ns

module l1d_data_sram #(
    parameter int NUM_WAYS = 4
) (
    input  logic                             clk,
    input  logic                             read_en,
    input  logic [$clog2(NUM_WAYS)-1:0]      read_way,
    input  dcache_pkg::l1d_set_idx_t         read_set,
    input  logic                             write_en,
    input  logic [$clog2(NUM_WAYS)-1:0]      write_way,
    input  dcache_pkg::l1d_set_idx_t         write_set,
    input  dcache_pkg::cache_line_data_t     write_data,
    output dcache_pkg::cache_line_data_t     read_data
);

    dcache_pkg::cache_line_data_t lines[NUM_WAYS * dcache_pkg::NUM_SETS];

    always_ff @(posedge clk)
    begin
        if (write_en)
            lines[{write_way, write_set}] <= write_data;

        if (read_en)
        begin
            if (write_en && {write_way, write_set} == {read_way, read_set})
                read_data <= write_data;
            else
                read_data <= lines[{read_way, read_set}];
        end
    end

endmodule

/* sim/tb_dcache_tasks.svh */
// ======================================================================
// Shared testbench tasks for the data stage testbench.
// Included inside the testbench module, so the tasks drive and sample
// its signals directly: value check, request drive, line fill and a
// result wait that gives up after a few cycles.
// ======================================================================

task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check(input string name, input logic [511:0] actual,
    input logic [511:0] expected);
    if (actual !== expected)
    begin
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        abort_run();
    end
endtask

function automatic dcache_pkg::cache_line_data_t random_line();
    dcache_pkg::cache_line_data_t line;
    for (int i = 0; i < dcache_pkg::CACHE_LINE_WORDS; i++)
        line[i * 32 +: 32] = $urandom;
    return line;
endfunction

// Called 2 ns after a rising edge, returns mid-cycle with outputs settled
task automatic drive_request(input logic is_load, input mem_op_pkg::mem_op_t op,
    input mem_op_pkg::thread_idx_t thread, input logic [31:0] addr,
    input dcache_pkg::vector_mask_t mask, input dcache_pkg::vector_t value);
    dcache_pkg::l1d_set_idx_t set_idx;
    set_idx = addr[11:6];
    request.valid = 1'b1;
    request.is_load = is_load;
    request.op = op;
    request.thread = thread;
    request.paddr = addr;
    request.mask = mask;
    request.store_value = value;
    // Tag stage view of the addressed set
    for (int w = 0; w < NUM_WAYS; w++)
    begin
        way_valid[w] = model_valid[w][set_idx];
        way_tag[w] = model_tag[w][set_idx];
    end
    #(CLK_PERIOD / 4);
endtask

task automatic fill_line(input logic [$clog2(NUM_WAYS)-1:0] way,
    input dcache_pkg::l1d_set_idx_t set_idx, input dcache_pkg::l1d_tag_t tag,
    input dcache_pkg::cache_line_data_t data);
    data_fill_en = 1'b1;
    data_fill_way = way;
    data_fill_set = set_idx;
    data_fill_data = data;
    @(posedge clk);
    #DRIVE_DELAY;
    data_fill_en = 1'b0;
    model_valid[way][set_idx] = 1'b1;
    model_tag[way][set_idx] = tag;
    model_line[way][set_idx] = data;
endtask

// Result should follow the request by exactly one clock
task automatic wait_result();
    int cycles;
    cycles = 0;
    do
    begin
        @(posedge clk);
        #DRIVE_DELAY;
        cycles++;
    end
    while (!result.valid && cycles < RESULT_TIMEOUT);
    request.valid = 1'b0;
    if (!result.valid)
    begin
        $display("Timed out after %0d cycles waiting for result.valid", cycles);
        abort_run();
    end
    check("result latency", cycles, 1);
endtask

/* sim/tb_dcache_data_stage.sv */
// ======================================================================
// Testbench for the L1 data cache data stage.
// Keeps a tag and line model filled through the fill ports and runs
// directed tests for stores, hits, misses, near misses, sync loads and
// misaligned accesses.
// ======================================================================
`timescale 1ns/1ns

module tb_dcache_data_stage;

    localparam int NUM_WAYS = 4;
    localparam int NUM_THREADS = 4;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY = 2;
    localparam int RESULT_TIMEOUT = 4;
    localparam int HIT_WAY = 2;
    localparam int HIT_SET = 5;

    logic clk;
    logic reset;
    mem_op_pkg::dcache_request_t request;
    logic way_valid[NUM_WAYS];
    dcache_pkg::l1d_tag_t way_tag[NUM_WAYS];
    dcache_pkg::l1d_tag_fill_t tag_fill;
    logic data_fill_en;
    logic [$clog2(NUM_WAYS)-1:0] data_fill_way;
    dcache_pkg::l1d_set_idx_t data_fill_set;
    dcache_pkg::cache_line_data_t data_fill_data;
    mem_op_pkg::miss_request_t miss;
    mem_op_pkg::store_request_t store;
    logic lru_update_en;
    logic [$clog2(NUM_WAYS)-1:0] lru_update_way;
    mem_op_pkg::stage_result_t result;
    dcache_pkg::cache_line_data_t load_data;
    logic [NUM_THREADS-1:0] load_sync_pending;

    // Model of the tag and data arrays
    logic model_valid[NUM_WAYS][dcache_pkg::NUM_SETS];
    dcache_pkg::l1d_tag_t model_tag[NUM_WAYS][dcache_pkg::NUM_SETS];
    dcache_pkg::cache_line_data_t model_line[NUM_WAYS][dcache_pkg::NUM_SETS];
    dcache_pkg::l1d_tag_t hit_tag;

    dcache_data_stage #(
        .NUM_WAYS(NUM_WAYS),
        .NUM_THREADS(NUM_THREADS)
    ) uut (
        .clk(clk),
        .reset(reset),
        .request(request),
        .way_valid(way_valid),
        .way_tag(way_tag),
        .tag_fill(tag_fill),
        .data_fill_en(data_fill_en),
        .data_fill_way(data_fill_way),
        .data_fill_set(data_fill_set),
        .data_fill_data(data_fill_data),
        .miss(miss),
        .store(store),
        .lru_update_en(lru_update_en),
        .lru_update_way(lru_update_way),
        .result(result),
        .load_data(load_data),
        .load_sync_pending(load_sync_pending)
    );

    `include "tb_dcache_tasks.svh"

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Word 0 owns the top four mask bits
    function automatic logic [63:0] expected_mask(input mem_op_pkg::mem_op_t op,
        input logic [5:0] offset, input dcache_pkg::vector_mask_t mask);
        logic [63:0] m;
        logic [3:0] sel;
        m = '0;
        case (op)
            mem_op_pkg::MEM_B: sel = 4'b1000 >> offset[1:0];
            mem_op_pkg::MEM_S: sel = offset[1] ? 4'b0011 : 4'b1100;
            default: sel = 4'b1111;
        endcase
        for (int w = 0; w < 16; w++)
        begin
            if (op == mem_op_pkg::MEM_BLOCK ? mask[w] : w == offset[5:2])
                m[63 - 4 * w -: 4] = sel;
        end
        return m;
    endfunction

    // Lowest byte of each lane holds the top byte of the value
    function automatic dcache_pkg::cache_line_data_t expected_store_data(
        input mem_op_pkg::mem_op_t op, input dcache_pkg::vector_t value);
        dcache_pkg::cache_line_data_t d;
        int lane;
        int k;
        for (int b = 0; b < 64; b++)
        begin
            lane = b / 4;
            k = b % 4;
            case (op)
                mem_op_pkg::MEM_B: d[8 * b +: 8] = value[0][7:0];
                mem_op_pkg::MEM_S: d[8 * b +: 8] = value[0][8 * (1 - b % 2) +: 8];
                mem_op_pkg::MEM_BLOCK: d[8 * b +: 8] = value[lane][8 * (3 - k) +: 8];
                default: d[8 * b +: 8] = value[0][8 * (3 - k) +: 8];
            endcase
        end
        return d;
    endfunction

    task automatic store_case(input mem_op_pkg::mem_op_t op, input logic [31:0] addr,
        input dcache_pkg::vector_mask_t mask);
        dcache_pkg::vector_t value;
        value = random_line();
        drive_request(1'b0, op, 4'd1, addr, mask, value);
        check("store.en", store.en, 1'b1);
        check("store.byte_mask", store.byte_mask, expected_mask(op, addr[5:0], mask));
        check("store.data", store.data, expected_store_data(op, value));
        check("store.line", store.line, addr[31:6]);
        check("store.thread", store.thread, 4'd1);
        check("store.sync", store.sync, op == mem_op_pkg::MEM_SYNC);
        check("miss.en", miss.en, 1'b0);
        wait_result();
        check("result.fault", result.fault, 1'b0);
    endtask

    task automatic test_stores();
        logic [31:0] base;
        base = $urandom & 32'hffff_fffc;
        for (int i = 0; i < 4; i++)
            store_case(mem_op_pkg::MEM_B, base + i, '0);
        store_case(mem_op_pkg::MEM_S, base, '0);
        store_case(mem_op_pkg::MEM_S, base + 2, '0);
        store_case(mem_op_pkg::MEM_L, base, '0);
        store_case(mem_op_pkg::MEM_SYNC, base, '0);
        store_case(mem_op_pkg::MEM_BLOCK, base & 32'hffff_ffc0, $urandom | 1);
    endtask

    task automatic test_load_hit();
        hit_tag = $urandom;
        // Neighbour way with a different tag in the same set
        fill_line(0, HIT_SET, hit_tag ^ 20'h1, random_line());
        fill_line(HIT_WAY, HIT_SET, hit_tag, random_line());
        drive_request(1'b1, mem_op_pkg::MEM_L, 4'd1, {hit_tag, 6'(HIT_SET), 6'd12}, '0, '0);
        check("lru_update_en", lru_update_en, 1'b1);
        check("lru_update_way", lru_update_way, HIT_WAY);
        check("miss.en", miss.en, 1'b0);
        wait_result();
        check("load_data", load_data, model_line[HIT_WAY][HIT_SET]);
        check("result.rollback", result.rollback, 1'b0);
        check("result.thread", result.thread, 4'd1);
    endtask

    task automatic test_load_miss();
        logic [31:0] addr;
        addr = {hit_tag ^ 20'h3, 6'(HIT_SET), 6'd0};
        drive_request(1'b1, mem_op_pkg::MEM_L, 4'd2, addr, '0, '0);
        check("miss.en", miss.en, 1'b1);
        check("miss.line", miss.line, addr[31:6]);
        check("miss.thread", miss.thread, 4'd2);
        check("lru_update_en", lru_update_en, 1'b0);
        wait_result();
        check("result.rollback", result.rollback, 1'b1);
        check("result.suspend", result.suspend, 1'b1);
    endtask

    task automatic test_near_miss();
        dcache_pkg::l1d_tag_t tag;
        tag = $urandom;
        tag_fill.valid = 1'b1;
        tag_fill.set_idx = 6'd9;
        tag_fill.tag = tag;
        drive_request(1'b1, mem_op_pkg::MEM_L, 4'd0, {tag, 6'd9, 6'd4}, '0, '0);
        check("miss.en", miss.en, 1'b0);
        wait_result();
        tag_fill.valid = 1'b0;
        check("result.rollback", result.rollback, 1'b1);
        check("result.suspend", result.suspend, 1'b0);
    endtask

    task automatic test_sync_load();
        logic [31:0] addr;
        addr = {hit_tag, 6'(HIT_SET), 6'd8};
        // No sync load has run yet, so every thread starts clear
        check("load_sync_pending", load_sync_pending, 4'b0000);
        // First attempt registers with L2
        drive_request(1'b1, mem_op_pkg::MEM_SYNC, 4'd3, addr, '0, '0);
        check("miss.en", miss.en, 1'b1);
        check("miss.sync", miss.sync, 1'b1);
        check("lru_update_en", lru_update_en, 1'b0);
        wait_result();
        check("load_sync_pending", load_sync_pending, 4'b1000);
        check("result.rollback", result.rollback, 1'b1);
        drive_request(1'b1, mem_op_pkg::MEM_SYNC, 4'd3, addr, '0, '0);
        check("miss.en", miss.en, 1'b0);
        check("lru_update_en", lru_update_en, 1'b1);
        check("lru_update_way", lru_update_way, HIT_WAY);
        wait_result();
        check("load_sync_pending", load_sync_pending, 4'b0000);
        check("result.rollback", result.rollback, 1'b0);
        check("load_data", load_data, model_line[HIT_WAY][HIT_SET]);
    endtask

    task automatic misaligned_case(input logic is_load, input mem_op_pkg::mem_op_t op,
        input logic [31:0] addr);
        drive_request(is_load, op, 4'd2, addr, $urandom | 1, random_line());
        check("store.en", store.en, 1'b0);
        check("miss.en", miss.en, 1'b0);
        check("lru_update_en", lru_update_en, 1'b0);
        wait_result();
        check("result.fault", result.fault, 1'b1);
    endtask

    task automatic test_misaligned();
        misaligned_case(1'b0, mem_op_pkg::MEM_S, {hit_tag, 6'(HIT_SET), 6'd1});
        misaligned_case(1'b1, mem_op_pkg::MEM_L, {hit_tag, 6'(HIT_SET), 6'd2});
        misaligned_case(1'b0, mem_op_pkg::MEM_BLOCK, {hit_tag, 6'(HIT_SET), 6'd4});
    endtask

    initial
    begin
        int unsigned seed_value;
        seed_value = $urandom(11275);
        reset = 1'b1;
        request = '0;
        tag_fill = '0;
        data_fill_en = 1'b0;
        data_fill_way = '0;
        data_fill_set = '0;
        data_fill_data = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            way_valid[w] = 1'b0;
            way_tag[w] = '0;
            for (int s = 0; s < dcache_pkg::NUM_SETS; s++)
                model_valid[w][s] = 1'b0;
        end
        for (int i = 0; i < RESET_CYCLES; i++)
            @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        check("result after reset", result, '0);
        check("load_sync_pending after reset", load_sync_pending, '0);

        test_stores();
        test_load_hit();
        test_load_miss();
        test_near_miss();
        test_sync_load();
        test_misaligned();

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* source/dcache_access_ctrl.sv */
// ======================================================================
// Access control for the data stage.
// Decodes load and store enables, drives the miss, store and LRU
// strobes in the request cycle and registers the result one clock later.
// ======================================================================
`timescale 1ns/1ns

module dcache_access_ctrl #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  mem_op_pkg::dcache_request_t                request,
    input  logic                                       cache_hit,
    input  logic [$clog2(NUM_WAYS)-1:0]                hit_way,
    input  logic                                       near_miss,
    input  logic [dcache_pkg::CACHE_LINE_BYTES-1:0]    byte_mask,
    input  dcache_pkg::cache_line_data_t               store_data,
    input  logic                                       unaligned,
    output logic                                       load_en,
    output logic                                       read_en,
    output mem_op_pkg::miss_request_t                  miss,
    output mem_op_pkg::store_request_t                 store,
    output logic                                       lru_update_en,
    output logic [$clog2(NUM_WAYS)-1:0]                lru_update_way,
    output mem_op_pkg::stage_result_t                  result
);

    logic access_en;
    logic store_en;
    logic is_sync;

    assign access_en = request.valid;
    assign load_en = access_en && request.is_load;
    // A store with an empty mask has nothing to write
    assign store_en = access_en && !request.is_load && byte_mask != '0;
    assign is_sync = request.op == mem_op_pkg::MEM_SYNC;

    assign read_en = load_en && cache_hit;

    // Near miss retries by rollback alone, no new L2 request
    assign miss.en = load_en && !cache_hit && !near_miss && !unaligned;
    assign miss.sync = is_sync;
    assign miss.thread = request.thread;
    assign miss.line = request.paddr.line_view.line;

    assign store.en = store_en && !unaligned;
    assign store.sync = is_sync;
    assign store.thread = request.thread;
    assign store.line = request.paddr.line_view.line;
    assign store.byte_mask = byte_mask;
    assign store.data = store_data;

    assign lru_update_en = access_en && cache_hit && !unaligned;
    assign lru_update_way = hit_way;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            result <= '0;
        else
        begin
            result.valid <= request.valid;
            result.thread <= request.thread;
            result.rollback <= load_en && !cache_hit;
            // Thread sleeps until the L2 fill wakes it
            result.suspend <= miss.en;
            result.fault <= (load_en || store_en) && unaligned;
        end
    end

endmodule

/* source/dcache_data_stage.sv */
// ======================================================================
// Data stage of the multithreaded L1 data cache.
// Takes a request with its tags already read, checks for a hit, reads
// the line, builds store data and registers the per-request result.
// NUM_WAYS and NUM_THREADS are set here and passed to the blocks.
// ======================================================================
`timescale 1ns/1ns

module dcache_data_stage #(
    parameter int NUM_WAYS = 4,
    parameter int NUM_THREADS = 4
) (
    input  logic                             clk,
    input  logic                             reset,

    // From the tag stage
    input  mem_op_pkg::dcache_request_t      request,
    input  logic                             way_valid[NUM_WAYS],
    input  dcache_pkg::l1d_tag_t             way_tag[NUM_WAYS],
    input  dcache_pkg::l1d_tag_fill_t        tag_fill,

    // Line fill from the L2 interface
    input  logic                             data_fill_en,
    input  logic [$clog2(NUM_WAYS)-1:0]      data_fill_way,
    input  dcache_pkg::l1d_set_idx_t         data_fill_set,
    input  dcache_pkg::cache_line_data_t     data_fill_data,

    // To the L2 interface
    output mem_op_pkg::miss_request_t        miss,
    output mem_op_pkg::store_request_t       store,

    // To the tag stage
    output logic                             lru_update_en,
    output logic [$clog2(NUM_WAYS)-1:0]      lru_update_way,

    // To writeback and decode
    output mem_op_pkg::stage_result_t        result,
    output dcache_pkg::cache_line_data_t     load_data,
    output logic [NUM_THREADS-1:0]           load_sync_pending
);

    logic cache_hit;
    logic [$clog2(NUM_WAYS)-1:0] hit_way;
    logic near_miss;
    logic load_en;
    logic read_en;
    logic [dcache_pkg::CACHE_LINE_BYTES-1:0] byte_mask;
    dcache_pkg::cache_line_data_t store_data;
    logic unaligned;

    dcache_hit_check #(
        .NUM_WAYS(NUM_WAYS),
        .NUM_THREADS(NUM_THREADS)
    ) hit_check (
        .clk(clk),
        .reset(reset),
        .request(request),
        .way_valid(way_valid),
        .way_tag(way_tag),
        .tag_fill(tag_fill),
        .load_en(load_en),
        .cache_hit(cache_hit),
        .hit_way(hit_way),
        .near_miss(near_miss),
        .load_sync_pending(load_sync_pending)
    );

    store_align store_align (
        .request(request),
        .byte_mask(byte_mask),
        .store_data(store_data),
        .unaligned(unaligned)
    );

    l1d_data_sram #(
        .NUM_WAYS(NUM_WAYS)
    ) data_sram (
        .clk(clk),
        .read_en(read_en),
        .read_way(hit_way),
        .read_set(request.paddr.tag_view.set_idx),
        .write_en(data_fill_en),
        .write_way(data_fill_way),
        .write_set(data_fill_set),
        .write_data(data_fill_data),
        .read_data(load_data)
    );

    dcache_access_ctrl #(
        .NUM_WAYS(NUM_WAYS)
    ) access_ctrl (
        .clk(clk),
        .reset(reset),
        .request(request),
        .cache_hit(cache_hit),
        .hit_way(hit_way),
        .near_miss(near_miss),
        .byte_mask(byte_mask),
        .store_data(store_data),
        .unaligned(unaligned),
        .load_en(load_en),
        .read_en(read_en),
        .miss(miss),
        .store(store),
        .lru_update_en(lru_update_en),
        .lru_update_way(lru_update_way),
        .result(result)
    );

endmodule

/* source/store_align.sv */
// ======================================================================
// Store formatting for the data stage.
// Builds the 64-bit byte mask and byte-swapped line data for each
// memory operation kind, and flags unaligned addresses.
// Purely combinational.
// ======================================================================
`timescale 1ns/1ns

module store_align (
    input  mem_op_pkg::dcache_request_t                request,
    output logic [dcache_pkg::CACHE_LINE_BYTES-1:0]    byte_mask,
    output dcache_pkg::cache_line_data_t               store_data,
    output logic                                       unaligned
);

    logic [dcache_pkg::CACHE_LINE_OFFSET_WIDTH-1:0] offset;
    dcache_pkg::vector_mask_t word_mask;
    logic [3:0] byte_sel;
    dcache_pkg::scalar_t scalar_value;
    dcache_pkg::cache_line_data_t swapped_lanes;

    assign offset = request.paddr.tag_view.offset;
    assign scalar_value = request.store_value[0];

    always_comb
    begin
        word_mask = '0;
        if (request.op == mem_op_pkg::MEM_BLOCK)
            word_mask = request.mask;
        else
            word_mask[offset[dcache_pkg::CACHE_LINE_OFFSET_WIDTH-1:2]] = 1'b1;
    end

    // Each vector lane byte-swapped in place
    for (genvar lane = 0; lane < dcache_pkg::CACHE_LINE_WORDS; lane++)
    begin : swap_gen
        assign swapped_lanes[lane * 32 +: 32] = {
            request.store_value[lane][7:0], request.store_value[lane][15:8],
            request.store_value[lane][23:16], request.store_value[lane][31:24]};
    end

    always_comb
    begin
        case (request.op)
            mem_op_pkg::MEM_B:
            begin
                store_data = {dcache_pkg::CACHE_LINE_BYTES{scalar_value[7:0]}};
                case (offset[1:0])
                    2'd0: byte_sel = 4'b1000;
                    2'd1: byte_sel = 4'b0100;
                    2'd2: byte_sel = 4'b0010;
                    default: byte_sel = 4'b0001;
                endcase
            end

            mem_op_pkg::MEM_S:
            begin
                store_data = {dcache_pkg::CACHE_LINE_WORDS * 2{scalar_value[7:0],
                    scalar_value[15:8]}};
                byte_sel = offset[1] ? 4'b0011 : 4'b1100;
            end

            mem_op_pkg::MEM_L, mem_op_pkg::MEM_SYNC:
            begin
                store_data = {dcache_pkg::CACHE_LINE_WORDS{scalar_value[7:0],
                    scalar_value[15:8], scalar_value[23:16], scalar_value[31:24]}};
                byte_sel = 4'b1111;
            end

            default:
            begin
                store_data = swapped_lanes;
                byte_sel = 4'b1111;
            end
        endcase
    end

    // Word 0 sits in the top four bytes of the mask
    for (genvar b = 0; b < dcache_pkg::CACHE_LINE_BYTES; b++)
    begin : mask_gen
        assign byte_mask[b] = word_mask[(dcache_pkg::CACHE_LINE_BYTES - 1 - b) / 4]
            & byte_sel[b % 4];
    end

    always_comb
    begin
        case (request.op)
            mem_op_pkg::MEM_S: unaligned = offset[0];
            mem_op_pkg::MEM_L, mem_op_pkg::MEM_SYNC: unaligned = |offset[1:0];
            mem_op_pkg::MEM_BLOCK: unaligned = offset != '0;
            default: unaligned = 1'b0;
        endcase
    end

endmodule

/* src.f */
+incdir+sim
common/dcache_pkg.sv
common/mem_op_pkg.sv
dcache/dcache_hit_check.sv
dcache/l1d_data_sram.sv
source/store_align.sv
source/dcache_access_ctrl.sv
source/dcache_data_stage.sv
sim/tb_dcache_data_stage.sv
